//--- hw/id_defines.svh
`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

// Datapath widths
`define ID_DATA_W       32
`define ID_REG_ADDR_W   5
`define ID_NUM_REGS     32
`define ID_IMM_W        16

// Instruction word fields
`define ID_OPCODE_MSB   31
`define ID_OPCODE_LSB   26
`define ID_RS_LSB       21
`define ID_RT_LSB       16
`define ID_RD_LSB       11
`define ID_SA_LSB       6
`define ID_FUNCT_W      6    // Function field sits in the low bits

`endif

//--- hw/id_pkg.sv
`include "id_defines.svh"

package id_pkg;

    typedef enum logic [`ID_OPCODE_MSB-`ID_OPCODE_LSB:0] {
        OPC_SPECIAL = 6'b000000,
        OPC_ADDI    = 6'b001000,
        OPC_ADDIU   = 6'b001001,
        OPC_SLTI    = 6'b001010,
        OPC_SLTIU   = 6'b001011,
        OPC_ANDI    = 6'b001100,
        OPC_ORI     = 6'b001101,
        OPC_XORI    = 6'b001110,
        OPC_LUI     = 6'b001111
    } opcode_e;

    typedef enum logic [`ID_FUNCT_W-1:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_e;

    // Result class picked by execute
    typedef enum logic [2:0] {
        RES_NOP   = 3'b000,
        RES_LOGIC = 3'b001,
        RES_SHIFT = 3'b010,
        RES_ARITH = 3'b100
    } alu_sel_e;

    typedef enum logic [7:0] {
        ALUOP_NOP  = 8'b00000000,
        ALUOP_AND  = 8'b00100100,
        ALUOP_OR   = 8'b00100101,
        ALUOP_XOR  = 8'b00100110,
        ALUOP_NOR  = 8'b00100111,
        ALUOP_SLL  = 8'b01111100,
        ALUOP_SRL  = 8'b00000010,
        ALUOP_SRA  = 8'b00000011,
        ALUOP_ADD  = 8'b00100000,
        ALUOP_ADDU = 8'b00100001,
        ALUOP_SUB  = 8'b00100010,
        ALUOP_SUBU = 8'b00100011,
        ALUOP_SLT  = 8'b00101010,
        ALUOP_SLTU = 8'b00101011
    } alu_op_e;

    typedef struct packed {
        logic                      wreg;
        logic [`ID_REG_ADDR_W-1:0] waddr;
        logic [`ID_DATA_W-1:0]     wdata;
    } reg_write_t;

    typedef struct packed {
        alu_sel_e                  alusel;
        alu_op_e                   aluop;
        logic                      rd1_en;
        logic                      rd2_en;
        logic [`ID_REG_ADDR_W-1:0] rd1_addr;
        logic [`ID_REG_ADDR_W-1:0] rd2_addr;
        logic [`ID_REG_ADDR_W-1:0] waddr;
        logic                      wreg;
        logic [`ID_DATA_W-1:0]     imm;
        logic                      legal;
    } decode_t;

    typedef struct packed {
        logic                      valid;
        logic                      legal;
        alu_sel_e                  alusel;
        alu_op_e                   aluop;
        logic [`ID_DATA_W-1:0]     opnd1;
        logic [`ID_DATA_W-1:0]     opnd2;
        logic [`ID_REG_ADDR_W-1:0] waddr;
        logic                      wreg;
    } id_ex_t;

endpackage

//--- hw/inst_decoder.sv
`include "id_defines.svh"

module inst_decoder (
    input  logic [`ID_DATA_W-1:0] inst_i,
    output id_pkg::decode_t       dec_o
);

    logic [`ID_OPCODE_MSB-`ID_OPCODE_LSB:0] opcode;
    logic [`ID_REG_ADDR_W-1:0]              rs;
    logic [`ID_REG_ADDR_W-1:0]              rt;
    logic [`ID_REG_ADDR_W-1:0]              rd;
    logic [`ID_REG_ADDR_W-1:0]              sa;
    logic [`ID_FUNCT_W-1:0]                 funct;
    logic [`ID_IMM_W-1:0]                   imm16;
    logic                                   shift_imm;

    assign opcode = inst_i[`ID_OPCODE_MSB:`ID_OPCODE_LSB];
    assign rs     = inst_i[`ID_RS_LSB +: `ID_REG_ADDR_W];
    assign rt     = inst_i[`ID_RT_LSB +: `ID_REG_ADDR_W];
    assign rd     = inst_i[`ID_RD_LSB +: `ID_REG_ADDR_W];
    assign sa     = inst_i[`ID_SA_LSB +: `ID_REG_ADDR_W];
    assign funct  = inst_i[`ID_FUNCT_W-1:0];
    assign imm16  = inst_i[`ID_IMM_W-1:0];

    // SLL, SRL and SRA take the shift amount from the word
    assign shift_imm = funct inside {id_pkg::FN_SLL, id_pkg::FN_SRL, id_pkg::FN_SRA};

    always_comb begin
        dec_o          = '0;
        dec_o.rd1_addr = rs;
        dec_o.rd2_addr = rt;
        dec_o.waddr    = rd;
        case (opcode)
            id_pkg::OPC_SPECIAL: begin
                dec_o.rd1_en = 1'b1;
                dec_o.rd2_en = 1'b1;
                dec_o.wreg   = 1'b1;
                dec_o.legal  = 1'b1;
                case (funct)
                    id_pkg::FN_SLL:  dec_o.aluop = id_pkg::ALUOP_SLL;
                    id_pkg::FN_SRL:  dec_o.aluop = id_pkg::ALUOP_SRL;
                    id_pkg::FN_SRA:  dec_o.aluop = id_pkg::ALUOP_SRA;
                    id_pkg::FN_SLLV: dec_o.aluop = id_pkg::ALUOP_SLL;
                    id_pkg::FN_SRLV: dec_o.aluop = id_pkg::ALUOP_SRL;
                    id_pkg::FN_SRAV: dec_o.aluop = id_pkg::ALUOP_SRA;
                    id_pkg::FN_ADD:  dec_o.aluop = id_pkg::ALUOP_ADD;
                    id_pkg::FN_ADDU: dec_o.aluop = id_pkg::ALUOP_ADDU;
                    id_pkg::FN_SUB:  dec_o.aluop = id_pkg::ALUOP_SUB;
                    id_pkg::FN_SUBU: dec_o.aluop = id_pkg::ALUOP_SUBU;
                    id_pkg::FN_AND:  dec_o.aluop = id_pkg::ALUOP_AND;
                    id_pkg::FN_OR:   dec_o.aluop = id_pkg::ALUOP_OR;
                    id_pkg::FN_XOR:  dec_o.aluop = id_pkg::ALUOP_XOR;
                    id_pkg::FN_NOR:  dec_o.aluop = id_pkg::ALUOP_NOR;
                    id_pkg::FN_SLT:  dec_o.aluop = id_pkg::ALUOP_SLT;
                    id_pkg::FN_SLTU: dec_o.aluop = id_pkg::ALUOP_SLTU;
                    default:         dec_o.legal = 1'b0;
                endcase
                if (shift_imm) begin
                    dec_o.alusel = id_pkg::RES_SHIFT;
                    dec_o.rd1_en = 1'b0;                  // Operand 1 is the shift amount
                    dec_o.imm    = {{(`ID_DATA_W-`ID_REG_ADDR_W){1'b0}}, sa};
                    if (rs != '0) begin
                        dec_o.legal = 1'b0;
                    end
                end else begin
                    if (sa != '0) begin
                        dec_o.legal = 1'b0;
                    end
                    if (funct inside {id_pkg::FN_SLLV, id_pkg::FN_SRLV, id_pkg::FN_SRAV}) begin
                        dec_o.alusel = id_pkg::RES_SHIFT;
                    end else if (funct inside {id_pkg::FN_AND, id_pkg::FN_OR,
                                               id_pkg::FN_XOR, id_pkg::FN_NOR}) begin
                        dec_o.alusel = id_pkg::RES_LOGIC;
                    end else begin
                        dec_o.alusel = id_pkg::RES_ARITH;
                    end
                end
            end
            default: begin
                // Immediate forms read rs and write rt
                dec_o.rd1_en = 1'b1;
                dec_o.waddr  = rt;
                dec_o.wreg   = 1'b1;
                dec_o.legal  = 1'b1;
                case (opcode)
                    id_pkg::OPC_ADDI:  dec_o.aluop = id_pkg::ALUOP_ADD;
                    id_pkg::OPC_ADDIU: dec_o.aluop = id_pkg::ALUOP_ADDU;
                    id_pkg::OPC_SLTI:  dec_o.aluop = id_pkg::ALUOP_SLT;
                    id_pkg::OPC_SLTIU: dec_o.aluop = id_pkg::ALUOP_SLTU;
                    id_pkg::OPC_ANDI:  dec_o.aluop = id_pkg::ALUOP_AND;
                    id_pkg::OPC_ORI:   dec_o.aluop = id_pkg::ALUOP_OR;
                    id_pkg::OPC_XORI:  dec_o.aluop = id_pkg::ALUOP_XOR;
                    id_pkg::OPC_LUI:   dec_o.aluop = id_pkg::ALUOP_OR;
                    default:           dec_o.legal = 1'b0;
                endcase
                if (opcode inside {id_pkg::OPC_ANDI, id_pkg::OPC_ORI, id_pkg::OPC_XORI}) begin
                    dec_o.alusel = id_pkg::RES_LOGIC;
                    dec_o.imm    = {{(`ID_DATA_W-`ID_IMM_W){1'b0}}, imm16};
                end else if (opcode == id_pkg::OPC_LUI) begin
                    dec_o.alusel = id_pkg::RES_LOGIC;
                    dec_o.imm    = {imm16, {(`ID_DATA_W-`ID_IMM_W){1'b0}}};  // rs | (imm << 16)
                    if (rs != '0) begin
                        dec_o.legal = 1'b0;
                    end
                end else begin
                    dec_o.alusel = id_pkg::RES_ARITH;
                    dec_o.imm    = {{(`ID_DATA_W-`ID_IMM_W){imm16[`ID_IMM_W-1]}}, imm16};
                end
            end
        endcase
        // Anything not decoded becomes a bubble with zero operands
        if (!dec_o.legal) begin
            dec_o = '0;
        end
    end

endmodule

//--- hw/reg_file.sv
`include "id_defines.svh"

module reg_file (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic [`ID_REG_ADDR_W-1:0] raddr1_i,
    input  logic [`ID_REG_ADDR_W-1:0] raddr2_i,
    output logic [`ID_DATA_W-1:0]     rdata1_o,
    output logic [`ID_DATA_W-1:0]     rdata2_o,
    input  id_pkg::reg_write_t        wr_i
);

    logic [`ID_DATA_W-1:0] regs_q [`ID_NUM_REGS];

    function automatic logic [`ID_DATA_W-1:0] read_port(input logic [`ID_REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;                                  // r0 is hardwired
        end else if (wr_i.wreg && (wr_i.waddr == addr)) begin
            return wr_i.wdata;                          // Same-cycle writeback bypass
        end else begin
            return regs_q[addr];
        end
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `ID_NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_i.wreg && (wr_i.waddr != '0)) begin
            regs_q[wr_i.waddr] <= wr_i.wdata;
        end
    end

    always_comb begin
        rdata1_o = read_port(raddr1_i);
        rdata2_o = read_port(raddr2_i);
    end

endmodule

//--- hw/operand_forward.sv
`include "id_defines.svh"

module operand_forward (
    input  logic                      rd_en_i,
    input  logic [`ID_REG_ADDR_W-1:0] raddr_i,
    input  logic [`ID_DATA_W-1:0]     reg_data_i,
    input  logic [`ID_DATA_W-1:0]     imm_i,
    input  id_pkg::reg_write_t        ex_fwd_i,
    input  id_pkg::reg_write_t        mem_fwd_i,
    output logic [`ID_DATA_W-1:0]     opnd_o
);

    logic ex_hit;
    logic mem_hit;

    assign ex_hit  = ex_fwd_i.wreg && (ex_fwd_i.waddr == raddr_i);
    assign mem_hit = mem_fwd_i.wreg && (mem_fwd_i.waddr == raddr_i);

    // Youngest result wins, so execute is checked before memory
    always_comb begin
        if (!rd_en_i) begin
            opnd_o = imm_i;
        end else if (ex_hit) begin
            opnd_o = ex_fwd_i.wdata;
        end else if (mem_hit) begin
            opnd_o = mem_fwd_i.wdata;
        end else begin
            opnd_o = reg_data_i;
        end
    end

endmodule

//--- hw/id_stage.sv
`include "id_defines.svh"

module id_stage (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  inst_valid_i,
    input  logic [`ID_DATA_W-1:0] inst_i,
    input  id_pkg::reg_write_t    ex_fwd_i,
    input  id_pkg::reg_write_t    mem_fwd_i,
    input  id_pkg::reg_write_t    wb_i,
    output id_pkg::id_ex_t        id_ex_o
);

    id_pkg::decode_t dec;
    logic [`ID_DATA_W-1:0] rdata1, rdata2;
    logic [`ID_DATA_W-1:0] opnd1, opnd2;

    logic                      valid_q, legal_q, wreg_q;
    id_pkg::alu_sel_e          alusel_q;
    id_pkg::alu_op_e           aluop_q;
    logic [`ID_DATA_W-1:0]     opnd1_q, opnd2_q;
    logic [`ID_REG_ADDR_W-1:0] waddr_q;

    inst_decoder u_inst_decoder (
        .inst_i (inst_i),
        .dec_o  (dec)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .raddr1_i (dec.rd1_addr),
        .raddr2_i (dec.rd2_addr),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2),
        .wr_i     (wb_i)
    );

    operand_forward u_fwd_opnd1 (
        .rd_en_i    (dec.rd1_en),
        .raddr_i    (dec.rd1_addr),
        .reg_data_i (rdata1),
        .imm_i      (dec.imm),
        .ex_fwd_i   (ex_fwd_i),
        .mem_fwd_i  (mem_fwd_i),
        .opnd_o     (opnd1)
    );

    operand_forward u_fwd_opnd2 (
        .rd_en_i    (dec.rd2_en),
        .raddr_i    (dec.rd2_addr),
        .reg_data_i (rdata2),
        .imm_i      (dec.imm),
        .ex_fwd_i   (ex_fwd_i),
        .mem_fwd_i  (mem_fwd_i),
        .opnd_o     (opnd2)
    );

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            legal_q <= 1'b0;
            wreg_q  <= 1'b0;
        end else begin
            valid_q <= inst_valid_i;                    // Bubble between strobes
            wreg_q  <= inst_valid_i && dec.wreg;
            if (inst_valid_i) begin
                legal_q <= dec.legal;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid_i) begin
            alusel_q <= dec.alusel;
            aluop_q  <= dec.aluop;
            opnd1_q  <= opnd1;
            opnd2_q  <= opnd2;
            waddr_q  <= dec.waddr;
        end
    end

    always_comb begin
        id_ex_o.valid  = valid_q;
        id_ex_o.legal  = legal_q;
        id_ex_o.alusel = alusel_q;
        id_ex_o.aluop  = aluop_q;
        id_ex_o.opnd1  = opnd1_q;
        id_ex_o.opnd2  = opnd2_q;
        id_ex_o.waddr  = waddr_q;
        id_ex_o.wreg   = wreg_q;
    end

endmodule

//--- verification/id_ref_model.svh
`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

logic [`ID_DATA_W-1:0] model_regs [`ID_NUM_REGS];

task automatic clear_regs();
    for (int i = 0; i < `ID_NUM_REGS; i++) begin
        model_regs[i] = '0;
    end
endtask

task automatic apply_writeback(input id_pkg::reg_write_t wb);
    if (wb.wreg && (wb.waddr != '0)) begin
        model_regs[wb.waddr] = wb.wdata;
    end
endtask

// Forwarding sits ahead of the register file and its hardwired r0
function automatic logic [`ID_DATA_W-1:0] predict_operand(
    input logic en, input logic [4:0] addr, input logic [`ID_DATA_W-1:0] imm,
    input id_pkg::reg_write_t ex, input id_pkg::reg_write_t mem, input id_pkg::reg_write_t wb);
    return !en                              ? imm :
           (ex.wreg && (ex.waddr == addr))   ? ex.wdata :
           (mem.wreg && (mem.waddr == addr)) ? mem.wdata :
           (addr == 5'd0)                    ? '0 :
           (wb.wreg && (wb.waddr == addr))   ? wb.wdata : model_regs[addr];
endfunction

function automatic id_pkg::decode_t decode_word(input logic [`ID_DATA_W-1:0] w);
    id_pkg::decode_t d;
    logic [5:0]      op;
    logic [5:0]      fn;
    op = w[31:26];
    fn = w[5:0];
    d = '0;
    d.legal    = 1'b1;
    d.wreg     = 1'b1;
    d.rd1_en   = 1'b1;
    d.rd1_addr = w[25:21];
    d.rd2_addr = w[20:16];
    if (op == 6'h00) begin
        d.rd2_en = 1'b1;
        d.waddr  = w[15:11];
        case (fn)
            6'h00, 6'h04: d.aluop = id_pkg::ALUOP_SLL;
            6'h02, 6'h06: d.aluop = id_pkg::ALUOP_SRL;
            6'h03, 6'h07: d.aluop = id_pkg::ALUOP_SRA;
            6'h20:        d.aluop = id_pkg::ALUOP_ADD;
            6'h21:        d.aluop = id_pkg::ALUOP_ADDU;
            6'h22:        d.aluop = id_pkg::ALUOP_SUB;
            6'h23:        d.aluop = id_pkg::ALUOP_SUBU;
            6'h24:        d.aluop = id_pkg::ALUOP_AND;
            6'h25:        d.aluop = id_pkg::ALUOP_OR;
            6'h26:        d.aluop = id_pkg::ALUOP_XOR;
            6'h27:        d.aluop = id_pkg::ALUOP_NOR;
            6'h2a:        d.aluop = id_pkg::ALUOP_SLT;
            6'h2b:        d.aluop = id_pkg::ALUOP_SLTU;
            default:      d.legal = 1'b0;
        endcase
        // Funct 0x00 to 0x07 are shifts and 0x24 to 0x27 are logic
        d.alusel = (fn[5:3] == 3'b000) ? id_pkg::RES_SHIFT :
                   (fn[5:2] == 4'b1001) ? id_pkg::RES_LOGIC : id_pkg::RES_ARITH;
        if (fn[5:2] == 4'b0000) begin
            d.rd1_en = 1'b0;                               // Shift by the sa field
            d.imm    = {27'd0, w[10:6]};
            d.legal  = d.legal && (w[25:21] == 5'd0);
        end else begin
            d.legal  = d.legal && (w[10:6] == 5'd0);
        end
    end else begin
        d.waddr = w[20:16];
        case (op)
            6'h08:   d.aluop = id_pkg::ALUOP_ADD;
            6'h09:   d.aluop = id_pkg::ALUOP_ADDU;
            6'h0a:   d.aluop = id_pkg::ALUOP_SLT;
            6'h0b:   d.aluop = id_pkg::ALUOP_SLTU;
            6'h0c:   d.aluop = id_pkg::ALUOP_AND;
            6'h0d:   d.aluop = id_pkg::ALUOP_OR;
            6'h0e:   d.aluop = id_pkg::ALUOP_XOR;
            6'h0f:   d.aluop = id_pkg::ALUOP_OR;
            default: d.legal = 1'b0;
        endcase
        d.alusel = op[2] ? id_pkg::RES_LOGIC : id_pkg::RES_ARITH;
        if (op == 6'h0f) begin
            d.imm   = {w[15:0], 16'h0000};                 // LUI
            d.legal = d.legal && (w[25:21] == 5'd0);
        end else begin
            d.imm   = op[2] ? {16'h0000, w[15:0]} : {{16{w[15]}}, w[15:0]};
        end
    end
    if (!d.legal) begin
        d = '0;
    end
    return d;
endfunction

`endif

//--- verification/tb_id_stage.sv
`include "id_defines.svh"

module tb_id_stage;

    localparam int RESET_CYCLES   = 5;
    localparam int NUM_CYCLES     = 2000;
    localparam int TIMEOUT_CYCLES = 3 * (NUM_CYCLES + RESET_CYCLES);

    // Kept register-format functions and immediate opcodes
    localparam logic [95:0] FUNCT_TBL = {6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h20, 6'h21,
                                         6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};
    localparam logic [47:0] OPC_TBL   = {6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f};

    logic                  clk;
    logic                  rst_n_i;
    logic                  inst_valid_i;
    logic [`ID_DATA_W-1:0] inst_i;
    id_pkg::reg_write_t    ex_fwd_i;
    id_pkg::reg_write_t    mem_fwd_i;
    id_pkg::reg_write_t    wb_i;
    id_pkg::id_ex_t        id_ex_o;
    id_pkg::id_ex_t        exp_ex;
    integer                seed;
    int                    ctrl_errors = 0;
    int                    opnd_errors = 0;
    int                    cycle_cnt   = 0;

    `include "id_ref_model.svh"

    id_stage id_stage_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .ex_fwd_i     (ex_fwd_i),
        .mem_fwd_i    (mem_fwd_i),
        .wb_i         (wb_i),
        .id_ex_o      (id_ex_o)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic compare_ctrl_field(input string name, input logic [7:0] act,
                                      input logic [7:0] exp);
        if (act !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, act, exp);
            ctrl_errors++;
        end
    endtask

    task automatic check_bundle(input id_pkg::id_ex_t act, input id_pkg::id_ex_t exp);
        compare_ctrl_field("id_ex_o.valid", act.valid, exp.valid);
        compare_ctrl_field("id_ex_o.wreg", act.wreg, exp.wreg);
        compare_ctrl_field("id_ex_o.legal", act.legal, exp.legal);
        if (exp.valid) begin
            compare_ctrl_field("id_ex_o.alusel", act.alusel, exp.alusel);
            compare_ctrl_field("id_ex_o.aluop", act.aluop, exp.aluop);
            compare_ctrl_field("id_ex_o.waddr", act.waddr, exp.waddr);
        end
    endtask

    task automatic check_operand(input string name, input logic [`ID_DATA_W-1:0] act,
                                 input logic [`ID_DATA_W-1:0] exp);
        if (act !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, act, exp);
            opnd_errors++;
        end
    endtask

    function automatic id_pkg::reg_write_t random_write();
        id_pkg::reg_write_t w;
        logic [31:0]        r;
        r       = $random(seed);
        w.wreg  = r[0];
        w.waddr = {2'b00, r[3:1]};                         // r0 to r7 keeps hazards frequent
        w.wdata = $random(seed);
        return w;
    endfunction

    function automatic logic [`ID_DATA_W-1:0] random_inst();
        logic [31:0] r;
        logic [31:0] w;
        logic [5:0]  code;
        logic [4:0]  rs;
        r  = $random(seed);
        w  = $random(seed);
        rs = {2'b00, r[2:0]};
        case (r[17:16])
            2'd0, 2'd1: begin
                code = FUNCT_TBL[int'(r[21:18]) * 6 +: 6];
                w = {6'h00, (code[5:2] == 4'b0000) ? 5'd0 : rs, 2'b00, r[5:3], 2'b00, r[8:6],
                     (code[5:2] == 4'b0000) ? r[13:9] : 5'd0, code};
            end
            2'd2: begin
                code = OPC_TBL[int'(r[20:18]) * 6 +: 6];
                w = {code, (code == 6'h0f) ? 5'd0 : rs, 2'b00, r[5:3], w[15:0]};
            end
            default: begin
                if (r[25]) begin
                    w[31:26] = 6'h00;                      // Mostly dropped SPECIAL functions
                end
            end
        endcase
        // Now and then break a must-be-zero field
        case (r[24:22])
            3'd0:    w[21] = ~w[21];
            3'd1:    w[6]  = ~w[6];
            default: ;
        endcase
        return w;
    endfunction

    task automatic drive_cycle();
        id_pkg::decode_t d;
        logic [31:0]     r;
        r            = $random(seed);
        inst_valid_i = (r[1:0] != 2'b00);
        inst_i       = random_inst();
        ex_fwd_i     = random_write();
        mem_fwd_i    = random_write();
        wb_i         = random_write();
        d            = decode_word(inst_i);
        exp_ex.valid = inst_valid_i;
        exp_ex.wreg  = inst_valid_i && d.wreg;
        if (inst_valid_i) begin
            exp_ex.legal  = d.legal;
            exp_ex.alusel = d.alusel;
            exp_ex.aluop  = d.aluop;
            exp_ex.waddr  = d.waddr;
            exp_ex.opnd1  = predict_operand(d.rd1_en, d.rd1_addr, d.imm,
                                            ex_fwd_i, mem_fwd_i, wb_i);
            exp_ex.opnd2  = predict_operand(d.rd2_en, d.rd2_addr, d.imm,
                                            ex_fwd_i, mem_fwd_i, wb_i);
        end
        apply_writeback(wb_i);                             // Visible from the next cycle on
    endtask

    initial begin
        seed         = 679;
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        ex_fwd_i     = '0;
        mem_fwd_i    = '0;
        wb_i         = '0;
        exp_ex       = '0;
        clear_regs();
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n_i = 1'b1;
        check_bundle(id_ex_o, exp_ex);                     // Reset state before any strobe
        for (int n = 0; n < NUM_CYCLES; n++) begin
            drive_cycle();
            @(negedge clk);
            check_bundle(id_ex_o, exp_ex);
            if (exp_ex.valid) begin
                check_operand("id_ex_o.opnd1", id_ex_o.opnd1, exp_ex.opnd1);
                check_operand("id_ex_o.opnd2", id_ex_o.opnd2, exp_ex.opnd2);
            end
        end
        $display("Control errors: %0d, operand errors: %0d", ctrl_errors, opnd_errors);
        if ((ctrl_errors + opnd_errors) == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+hw
+incdir+verification
hw/id_pkg.sv
hw/inst_decoder.sv
hw/reg_file.sv
hw/operand_forward.sv
hw/id_stage.sv
verification/tb_id_stage.sv

//--- Bender.yml
package:
  name: id_stage

sources:
  - target: any(rtl, test)
    include_dirs:
      - hw
    files:
      - hw/id_pkg.sv
      - hw/inst_decoder.sv
      - hw/reg_file.sv
      - hw/operand_forward.sv
      - hw/id_stage.sv
  - target: test
    include_dirs:
      - hw
      - verification
    files:
      - verification/tb_id_stage.sv
